// File: hdl/fir_pkg.sv
package fir_pkg;

  //////////////////////////////
  // word widths
  //////////////////////////////

  localparam int SAMPLE_W       = 16;  // sfix16_En15
  localparam int COEFF_W        = 16;  // sfix16_En19
  localparam int FULL_PRODUCT_W = 32;  // sfix32_En34, exact product
  localparam int PRODUCT_W      = 31;  // sfix31_En34, kept product
  localparam int ACC_W          = 35;  // sfix35_En34

  //////////////////////////////
  // payload types
  //////////////////////////////

  typedef logic signed [SAMPLE_W-1:0]  sample_t;   // input sample
  typedef logic signed [COEFF_W-1:0]   coeff_t;    // filter coefficient
  typedef logic signed [PRODUCT_W-1:0] product_t;  // one tap product
  typedef logic signed [ACC_W-1:0]     acc_t;      // running sum and output

  //////////////////////////////
  // filter geometry
  //////////////////////////////

  localparam int NUM_TAPS          = 32;
  localparam int NUM_UNIQUE_COEFFS = NUM_TAPS / 2;  // symmetric response

  //////////////////////////////
  // coefficient table
  //////////////////////////////

  // Only the first half of the impulse response is stored. The response is
  // even-symmetric, so tap i and tap NUM_TAPS-1-i share one entry. Entry 0
  // belongs to the outermost taps and entry 15 to the two centre taps.
  // All values are positive, the largest being entry 15.
  localparam coeff_t coeff_table [NUM_UNIQUE_COEFFS] = '{
    16'sh32DD,  // coeff1, taps 0 and 31
    16'sh18C9,  // coeff2
    16'sh1E35,  // coeff3
    16'sh23F9,  // coeff4
    16'sh29FA,  // coeff5
    16'sh301D,  // coeff6
    16'sh3640,  // coeff7
    16'sh3C41,  // coeff8
    16'sh41F9,  // coeff9
    16'sh4755,  // coeff10
    16'sh4C35,  // coeff11
    16'sh5076,  // coeff12
    16'sh53F5,  // coeff13
    16'sh56B2,  // coeff14
    16'sh588E,  // coeff15
    16'sh5979   // coeff16, taps 15 and 16
  };

  // Range notes for the fixed formats above:
  //   |sample| <= 2^15 and max coeff 0x5979 give |product| < 2^30,
  //   so the cut from 32 to 31 bits never changes a value.
  //   Sum of all 32 coefficient magnitudes times 2^15 stays below 2^34,
  //   so the 35-bit sum cannot wrap for any legal input stream.

endpackage

// File: hdl/tap_delay_line.sv
`timescale 1ns/100ps

module tap_delay_line #(
  parameter int TAP_DEPTH = fir_pkg::NUM_TAPS
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clk_enable,           // advance strobe
  input  fir_pkg::sample_t filter_in,            // newest sample
  output fir_pkg::sample_t taps [TAP_DEPTH]      // taps[0] newest
);

  //////////////////////////////
  // sample history
  //////////////////////////////

  // One register per tap. On an enabled edge every sample moves one place
  // towards the old end and the incoming sample lands in position 0.
  // The oldest sample simply falls off the far end.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TAP_DEPTH; i++) begin
        taps[i] <= '0;                           // empty history
      end
    end else if (clk_enable) begin
      taps[0] <= filter_in;                      // load new sample
      for (int i = 1; i < TAP_DEPTH; i++) begin
        taps[i] <= taps[i-1];                    // shift by one
      end
    end
  end

endmodule

// File: hdl/coeff_multiplier_bank.sv
`timescale 1ns/100ps

module coeff_multiplier_bank (
  input  fir_pkg::sample_t  taps     [fir_pkg::NUM_TAPS],  // sample history
  output fir_pkg::product_t products [fir_pkg::NUM_TAPS]   // one per tap
);

  //////////////////////////////
  // per-tap multipliers
  //////////////////////////////

  // Tap i reads table entry i in the first half and entry NUM_TAPS-1-i in
  // the second half, so the 16 stored values cover all 32 taps.

  for (genvar i = 0; i < fir_pkg::NUM_TAPS; i++) begin : g_tap

    localparam int COEFF_IDX = (i < fir_pkg::NUM_UNIQUE_COEFFS) ?
                               i : (fir_pkg::NUM_TAPS - 1 - i);  // mirror index

    localparam fir_pkg::coeff_t TAP_COEFF = fir_pkg::coeff_table[COEFF_IDX];

    logic signed [fir_pkg::FULL_PRODUCT_W-1:0] full_product;  // sfix32_En34

    // both operands signed, so the 32-bit result is a true signed product
    assign full_product = taps[i] * TAP_COEFF;

    // keep the low 31 bits, the top bit is only a copy of the sign here
    assign products[i] = full_product[fir_pkg::PRODUCT_W-1:0];

  end

endmodule

// File: hdl/product_accumulator.sv
`timescale 1ns/100ps

module product_accumulator (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clk_enable,                         // load strobe
  input  fir_pkg::product_t products [fir_pkg::NUM_TAPS],       // tap products
  output fir_pkg::acc_t     filter_out                          // registered sum
);

  localparam int EXT_W = fir_pkg::ACC_W - fir_pkg::PRODUCT_W;   // sign bits added

  fir_pkg::acc_t product_ext [fir_pkg::NUM_TAPS];  // products at sum width
  fir_pkg::acc_t sum_chain   [fir_pkg::NUM_TAPS];  // partial sums, tap order

  //////////////////////////////
  // sign extension
  //////////////////////////////

  for (genvar i = 0; i < fir_pkg::NUM_TAPS; i++) begin : g_ext
    assign product_ext[i] = {{EXT_W{products[i][fir_pkg::PRODUCT_W-1]}}, products[i]};
  end

  //////////////////////////////
  // adder chain
  //////////////////////////////

  // Each stage adds one more product to the previous partial sum. The
  // result is kept at 35 bits, so any carry out of the top bit is dropped.

  assign sum_chain[0] = product_ext[0];  // first tap seeds the chain

  for (genvar i = 1; i < fir_pkg::NUM_TAPS; i++) begin : g_sum
    assign sum_chain[i] = sum_chain[i-1] + product_ext[i];  // wraps at 35 bits
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // captures the sum of the taps as they stand before the enabled edge,
  // which puts the output one enabled edge behind the delay line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      filter_out <= '0;
    end else if (clk_enable) begin
      filter_out <= sum_chain[fir_pkg::NUM_TAPS-1];  // full 32-tap total
    end
  end

endmodule

// File: hdl/fir_top.sv
`timescale 1ns/100ps

module fir_top #(
  parameter int TAP_DEPTH = fir_pkg::NUM_TAPS  // history length
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clk_enable,        // sample strobe
  input  fir_pkg::sample_t filter_in,         // sfix16_En15
  output fir_pkg::acc_t    filter_out         // sfix35_En34
);

  fir_pkg::sample_t  taps     [TAP_DEPTH];          // delay line contents
  fir_pkg::product_t products [fir_pkg::NUM_TAPS];  // per-tap products

  //////////////////////////////
  // sample delay line
  //////////////////////////////

  tap_delay_line #(
    .TAP_DEPTH (TAP_DEPTH)
  ) delay_line_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .taps       (taps)
  );

  //////////////////////////////
  // coefficient multipliers
  //////////////////////////////

  // purely combinational, products follow the taps in the same cycle
  coeff_multiplier_bank mult_bank_i (
    .taps     (taps),
    .products (products)
  );

  //////////////////////////////
  // sum and output register
  //////////////////////////////

  product_accumulator accum_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clk_enable (clk_enable),
    .products   (products),
    .filter_out (filter_out)
  );

endmodule

// File: tb/fir_tb.sv
`timescale 1ns/100ps

module fir_tb;

  localparam logic [31:0] SEED    = 32'hfa9bb9eb;
  localparam int HALF_PERIOD      = 20;              // 40 ns clock
  localparam int SETTLE_LIMIT     = 40;              // enabled edges allowed to settle
  localparam int RANDOM_COUNT     = 200;             // enabled random samples
  localparam fir_pkg::sample_t FULL_NEG = 16'sh8000; // -32768
  localparam fir_pkg::sample_t FULL_POS = 16'sh7FFF; // +32767

  logic             clk;
  logic             rst_n;
  logic             clk_enable;
  fir_pkg::sample_t filter_in;
  fir_pkg::acc_t    filter_out;

  //////////////////////////////
  // reference model state
  //////////////////////////////

  fir_pkg::sample_t history [fir_pkg::NUM_TAPS];  // history[0] newest
  fir_pkg::acc_t    expected_out;                 // model output register
  logic             pending_en;                   // inputs waiting for the next edge
  fir_pkg::sample_t pending_x;

  fir_top #(
    .TAP_DEPTH (fir_pkg::NUM_TAPS)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

  // mirrored coefficient of one tap, read from the package table
  function automatic fir_pkg::coeff_t tap_coeff(input int tap);
    if (tap < fir_pkg::NUM_UNIQUE_COEFFS) begin
      return fir_pkg::coeff_table[tap];
    end
    return fir_pkg::coeff_table[fir_pkg::NUM_TAPS - 1 - tap];
  endfunction

  // sum over the current history, products cut to 31 bits, total wrapped to 35
  function automatic fir_pkg::acc_t reference_sum();
    longint            total;
    longint            full;
    fir_pkg::product_t kept;
    total = 0;
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      full  = longint'(history[i]) * longint'(tap_coeff(i));
      kept  = fir_pkg::product_t'(full);  // low 31 bits
      total = total + longint'(kept);
    end
    return fir_pkg::acc_t'(total);
  endfunction

  task automatic compare_value(input logic signed [63:0] actual,
                               input logic signed [63:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("error at time %0t ns: %s, got %0d, expected %0d",
               $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // One clock. New inputs go out on the rising edge, the model takes the
  // inputs the DUT captured on that same edge, and the check runs at the
  // falling edge.
  task automatic clock_cycle(input logic en, input fir_pkg::sample_t x,
                             input string what);
    @(posedge clk);
    clk_enable <= en;
    filter_in  <= x;
    if (pending_en) begin
      expected_out = reference_sum();       // sum of taps before the edge
      for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--) begin
        history[i] = history[i-1];
      end
      history[0] = pending_x;
    end
    pending_en = en;
    pending_x  = x;
    @(negedge clk);
    compare_value(filter_out, expected_out, what);
  endtask

  // hold one input value enabled until the output reaches the target
  task automatic settle_to(input fir_pkg::sample_t x, input longint target,
                           input string what);
    int edges;
    edges = 0;
    clock_cycle(1'b1, x, what);
    edges++;
    while (filter_out !== target) begin
      if (edges >= SETTLE_LIMIT) begin
        $display("timeout: %s did not settle within %0d enabled edges",
                 what, SETTLE_LIMIT);
        $display("TB FAILED");
        $fatal(1, "settle timeout");
      end
      clock_cycle(1'b1, x, what);
      edges++;
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_behavior();
    @(negedge clk);
    compare_value(filter_out, 0, "output right after reset");
    for (int k = 0; k < 8; k++) begin
      clock_cycle(1'b1, '0, "zero input after reset");
      compare_value(filter_out, 0, "output stays zero");
    end
  endtask

  task automatic impulse_response();
    clock_cycle(1'b1, 16'sd1, "impulse load");
    clock_cycle(1'b1, '0, "impulse capture");   // output still from empty taps
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
      clock_cycle(1'b1, '0, "impulse response");
      compare_value(filter_out, tap_coeff(k), "impulse coefficient");
    end
    settle_to('0, 0, "impulse tail");
  endtask

  task automatic full_scale_step();
    longint coeff_total;
    coeff_total = 0;
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      coeff_total = coeff_total + longint'(tap_coeff(i));
    end
    settle_to(FULL_NEG, longint'(FULL_NEG) * coeff_total, "negative full scale");
    for (int k = 0; k < 4; k++) begin
      clock_cycle(1'b1, FULL_NEG, "negative full scale hold");
    end
    settle_to(FULL_POS, longint'(FULL_POS) * coeff_total, "positive full scale");
    for (int k = 0; k < 4; k++) begin
      clock_cycle(1'b1, FULL_POS, "positive full scale hold");
    end
    settle_to('0, 0, "step release");
  endtask

  task automatic enable_hold();
    fir_pkg::acc_t held;
    for (int k = 0; k < 8; k++) begin
      clock_cycle(1'b1, fir_pkg::sample_t'($urandom), "hold preload");
    end
    clock_cycle(1'b0, fir_pkg::sample_t'($urandom), "hold entry");  // last enabled capture
    held = expected_out;
    for (int k = 0; k < 6; k++) begin
      clock_cycle(1'b0, fir_pkg::sample_t'($urandom), "input ignored while held");
      compare_value(filter_out, held, "output during hold");
    end
    for (int k = 0; k < 40; k++) begin
      clock_cycle(1'b1, fir_pkg::sample_t'($urandom), "resume after hold");
    end
  endtask

  task automatic random_stream();
    int   fed;
    logic en;
    fed = 0;
    while (fed < RANDOM_COUNT) begin
      en = ($urandom_range(3, 0) != 0);  // enabled about 3 cycles in 4
      if (en) begin
        fed++;
      end
      clock_cycle(en, fir_pkg::sample_t'($urandom), "random stream");
    end
    clock_cycle(1'b1, '0, "random stream flush");
    clock_cycle(1'b1, '0, "random stream flush");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n        <= 1'b0;
    clk_enable   <= 1'b0;
    filter_in    <= '0;
    pending_en   = 1'b0;
    pending_x    = '0;
    expected_out = '0;
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      history[i] = '0;
    end
    repeat (2) @(posedge clk);                 // reset over two rising edges
    rst_n <= 1'b1;

    reset_behavior();
    impulse_response();
    full_scale_step();
    enable_hold();
    random_stream();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: list.f
hdl/fir_pkg.sv
hdl/tap_delay_line.sv
hdl/coeff_multiplier_bank.sv
hdl/product_accumulator.sv
hdl/fir_top.sv
tb/fir_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the FIR filter testbench with Verilator.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
TOP=fir_tb

# build a simulation binary from the file list
verilator --binary --timing -Wno-fatal \
  -f list.f \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

if [ ! -x "$OBJ_DIR/V$TOP" ]; then
  echo "simulation binary $OBJ_DIR/V$TOP not found"
  exit 1
fi

# run the simulation and keep its output in memory
output=$("$OBJ_DIR/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run passes only if the pass line was printed
if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation did not pass"
  exit 1
fi
